// ==== Bender.yml ====
package:
  name: mipsCore

sources:
  - files:
      - hw/mipsPkg.sv
      - hw/mainDecoder.sv
      - hw/fetchStage.sv
      - hw/decodeStage.sv
      - hw/executeStage.sv
      - hw/mipsCore.sv
  - target: test
    files:
      - tb/clockGen.sv
      - tb/mipsCoreTb.sv

// ==== hw/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage (
    input  logic                              clk,
    input  logic                              arstN,
    input  logic [mipsPkg::DataWidth-1:0]     fdInstr,
    input  logic [mipsPkg::DataWidth-1:0]     fdPc,
    input  logic                              redirect,    // Squash the word in decode
    input  logic                              wbEn,
    input  logic [mipsPkg::RegAddrWidth-1:0]  wbReg,
    input  logic [mipsPkg::DataWidth-1:0]     wbData,
    output logic                              deRegWrite,
    output logic                              deMemRead,
    output logic                              deMemWrite,
    output logic                              deMemToReg,
    output logic                              deAluSrc,
    output logic                              deBranchEq,
    output logic                              deBranchNe,
    output logic                              deJump,
    output mipsPkg::aluOpT                    deAluOp,
    output logic [mipsPkg::DataWidth-1:0]     deRsVal,
    output logic [mipsPkg::DataWidth-1:0]     deRtVal,
    output logic [mipsPkg::DataWidth-1:0]     deImm,
    output mipsPkg::functT                    deFunct,
    output logic [mipsPkg::RegAddrWidth-1:0]  deDestReg,
    output logic [mipsPkg::TargetWidth-1:0]   deTarget,
    output logic [mipsPkg::DataWidth-1:0]     dePc
);

    import mipsPkg::*;

    instrT instr;
    logic  regDest, branchEq, branchNe, memRead, memToReg, memWrite;
    logic  aluSrc, regWrite, jump;
    aluOpT aluOp;

    logic [DataWidth-1:0]    regFile [32];
    logic [DataWidth-1:0]    rsVal;
    logic [DataWidth-1:0]    rtVal;
    logic [DataWidth-1:0]    immExt;
    logic [RegAddrWidth-1:0] destReg;

    assign instr = fdInstr;

    mainDecoder uDecoder (
        .opcode   (instr.r.opcode),
        .regDest  (regDest),
        .branchEq (branchEq),
        .branchNe (branchNe),
        .memRead  (memRead),
        .memToReg (memToReg),
        .memWrite (memWrite),
        .aluSrc   (aluSrc),
        .regWrite (regWrite),
        .jump     (jump),
        .aluOp    (aluOp)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Register file
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (wbEn)      // Never asserted for r0
            regFile[wbReg] <= wbData;
    end

    // Same-cycle writeback is forwarded to the read
    always_comb
    begin
        if (instr.i.rs == '0)
            rsVal = '0;
        else if (wbEn && wbReg == instr.i.rs)
            rsVal = wbData;
        else
            rsVal = regFile[instr.i.rs];

        if (instr.i.rt == '0)
            rtVal = '0;
        else if (wbEn && wbReg == instr.i.rt)
            rtVal = wbData;
        else
            rtVal = regFile[instr.i.rt];
    end

    assign immExt  = {{(DataWidth-ImmWidth){instr.i.imm[ImmWidth-1]}}, instr.i.imm};
    assign destReg = regDest ? instr.r.rd : instr.r.rt;

    ////////////////////////////////////////////////////////////////////////////
    // Decode to execute register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            {deRegWrite, deMemRead, deMemWrite, deMemToReg} <= '0;
            {deAluSrc, deBranchEq, deBranchNe, deJump}      <= '0;
            deAluOp <= AluAdd;
        end
        else if (redirect)     // Wrong path becomes NOP
        begin
            {deRegWrite, deMemRead, deMemWrite, deMemToReg} <= '0;
            {deAluSrc, deBranchEq, deBranchNe, deJump}      <= '0;
            deAluOp <= AluAdd;
        end
        else
        begin
            {deRegWrite, deMemRead, deMemWrite, deMemToReg} <=
                {regWrite, memRead, memWrite, memToReg};
            {deAluSrc, deBranchEq, deBranchNe, deJump} <= {aluSrc, branchEq, branchNe, jump};
            deAluOp <= aluOp;
        end
    end

    // Operands and fields
    always_ff @(posedge clk)
    begin
        deRsVal   <= rsVal;
        deRtVal   <= rtVal;
        deImm     <= immExt;
        deFunct   <= instr.r.funct;
        deDestReg <= destReg;
        deTarget  <= instr.j.target;
        dePc      <= fdPc;
    end

endmodule

// ==== hw/executeStage.sv ====
`timescale 1ns/1ps

module executeStage (
    input  logic                              deRegWrite,
    input  logic                              deMemRead,
    input  logic                              deMemWrite,
    input  logic                              deMemToReg,
    input  logic                              deAluSrc,
    input  logic                              deBranchEq,
    input  logic                              deBranchNe,
    input  logic                              deJump,
    input  mipsPkg::aluOpT                    deAluOp,
    input  logic [mipsPkg::DataWidth-1:0]     deRsVal,
    input  logic [mipsPkg::DataWidth-1:0]     deRtVal,
    input  logic [mipsPkg::DataWidth-1:0]     deImm,
    input  mipsPkg::functT                    deFunct,
    input  logic [mipsPkg::RegAddrWidth-1:0]  deDestReg,
    input  logic [mipsPkg::TargetWidth-1:0]   deTarget,
    input  logic [mipsPkg::DataWidth-1:0]     dePc,
    output logic [mipsPkg::DataWidth-1:0]     dmemAddr,
    output logic [mipsPkg::DataWidth-1:0]     dmemWData,
    output logic                              dmemWe,
    input  logic [mipsPkg::DataWidth-1:0]     dmemRData,
    output logic                              redirect,
    output logic [mipsPkg::DataWidth-1:0]     redirectPc,
    output logic                              wbEn,
    output logic [mipsPkg::RegAddrWidth-1:0]  wbReg,
    output logic [mipsPkg::DataWidth-1:0]     wbData
);

    import mipsPkg::*;

    aluCtlT               aluCtl;
    logic [DataWidth-1:0] aluB;
    logic [DataWidth-1:0] aluResult;
    logic                 aluZero;
    logic [DataWidth-1:0] pcPlus4;
    logic [DataWidth-1:0] branchTarget;
    logic [DataWidth-1:0] jumpTarget;
    logic                 branchTaken;
    logic [DataWidth-1:0] loadData;

    ////////////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (deAluOp)
            AluSub:   aluCtl = AluCtlSub;
            AluFunct:
            begin
                case (deFunct)
                    FnSub:   aluCtl = AluCtlSub;
                    FnAnd:   aluCtl = AluCtlAnd;
                    FnOr:    aluCtl = AluCtlOr;
                    FnSlt:   aluCtl = AluCtlSlt;
                    default: aluCtl = AluCtlAdd;   // FnAdd and unsupported funct
                endcase
            end
            default:  aluCtl = AluCtlAdd;
        endcase
    end

    assign aluB = deAluSrc ? deImm : deRtVal;

    always_comb
    begin
        case (aluCtl)
            AluCtlSub: aluResult = deRsVal - aluB;
            AluCtlAnd: aluResult = deRsVal & aluB;
            AluCtlOr:  aluResult = deRsVal | aluB;
            AluCtlSlt: aluResult = DataWidth'($signed(deRsVal) < $signed(aluB));
            default:   aluResult = deRsVal + aluB;
        endcase
    end

    assign aluZero = (aluResult == '0);

    ////////////////////////////////////////////////////////////////////////////
    // Control flow
    ////////////////////////////////////////////////////////////////////////////

    assign pcPlus4      = dePc + DataWidth'(4);
    assign branchTarget = pcPlus4 + {deImm[DataWidth-3:0], 2'b00};   // Word offset
    assign jumpTarget   = {pcPlus4[DataWidth-1:TargetWidth+2], deTarget, 2'b00};
    assign branchTaken  = (deBranchEq & aluZero) | (deBranchNe & ~aluZero);

    assign redirect   = branchTaken | deJump;
    assign redirectPc = deJump ? jumpTarget : branchTarget;

    // Data memory port
    assign dmemAddr  = aluResult;
    assign dmemWData = deRtVal;
    assign dmemWe    = deMemWrite;    // Write lands at the closing edge
    assign loadData  = deMemRead ? dmemRData : '0;

    // Writeback keeps r0 at zero
    assign wbEn   = deRegWrite && (deDestReg != '0);
    assign wbReg  = deDestReg;
    assign wbData = deMemToReg ? loadData : aluResult;

endmodule

// ==== hw/fetchStage.sv ====
`timescale 1ns/1ps

module fetchStage (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic                           redirect,    // Taken branch or jump in execute
    input  logic [mipsPkg::DataWidth-1:0]  redirectPc,
    output logic [mipsPkg::DataWidth-1:0]  imemAddr,
    input  logic [mipsPkg::DataWidth-1:0]  imemData,
    output logic [mipsPkg::DataWidth-1:0]  fdInstr,
    output logic [mipsPkg::DataWidth-1:0]  fdPc
);

    import mipsPkg::*;

    logic [DataWidth-1:0] pc;
    logic [DataWidth-1:0] pcNext;

    assign pcNext   = redirect ? redirectPc : pc + DataWidth'(4);
    assign imemAddr = pc;   // Combinational instruction port

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            pc      <= '0;
            fdInstr <= '0;     // NOP
        end
        else
        begin
            pc <= pcNext;
            // Wrong-path word is dropped
            if (redirect)
                fdInstr <= '0;
            else
                fdInstr <= imemData;
        end
    end

    // Address travels with its word
    always_ff @(posedge clk)
    begin
        fdPc <= pc;
    end

endmodule

// ==== hw/mainDecoder.sv ====
`timescale 1ns/1ps

module mainDecoder (
    input  mipsPkg::opcodeT opcode,
    output logic            regDest,    // rd instead of rt
    output logic            branchEq,
    output logic            branchNe,
    output logic            memRead,
    output logic            memToReg,   // Load data to writeback
    output logic            memWrite,
    output logic            aluSrc,     // Immediate as second operand
    output logic            regWrite,
    output logic            jump,
    output mipsPkg::aluOpT  aluOp
);

    import mipsPkg::*;

    always_comb
    begin
        // Everything off unless the opcode says otherwise
        regDest  = 1'b0;
        branchEq = 1'b0;
        branchNe = 1'b0;
        memRead  = 1'b0;
        memToReg = 1'b0;
        memWrite = 1'b0;
        aluSrc   = 1'b0;
        regWrite = 1'b0;
        jump     = 1'b0;
        aluOp    = AluAdd;

        case (opcode)
            OpRType:
            begin
                regDest  = 1'b1;
                regWrite = 1'b1;
                aluOp    = AluFunct;
            end
            OpAddi:
            begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            OpLw:
            begin
                memRead  = 1'b1;
                memToReg = 1'b1;
                aluSrc   = 1'b1;   // Base plus offset
                regWrite = 1'b1;
            end
            OpSw:
            begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
            end
            OpBeq:
            begin
                branchEq = 1'b1;
                aluOp    = AluSub;  // Zero result means equal
            end
            OpBne:
            begin
                branchNe = 1'b1;
                aluOp    = AluSub;
            end
            OpJ:
            begin
                jump = 1'b1;
            end
            default:
            begin
                // Unknown opcode behaves as NOP
            end
        endcase
    end

endmodule

// ==== hw/mipsCore.sv ====
`timescale 1ns/1ps

module mipsCore (
    input  logic                              clk,
    input  logic                              arstN,
    output logic [mipsPkg::DataWidth-1:0]     imemAddr,
    input  logic [mipsPkg::DataWidth-1:0]     imemData,
    output logic [mipsPkg::DataWidth-1:0]     dmemAddr,
    output logic [mipsPkg::DataWidth-1:0]     dmemWData,
    output logic                              dmemWe,
    input  logic [mipsPkg::DataWidth-1:0]     dmemRData,
    output logic                              wbEn,       // Retire strobe
    output logic [mipsPkg::RegAddrWidth-1:0]  wbReg,
    output logic [mipsPkg::DataWidth-1:0]     wbData
);

    import mipsPkg::*;

    // Fetch to decode
    logic [DataWidth-1:0] fdInstr, fdPc;

    // Decode to execute
    logic deRegWrite, deMemRead, deMemWrite, deMemToReg;
    logic deAluSrc, deBranchEq, deBranchNe, deJump;
    aluOpT                   deAluOp;
    logic [DataWidth-1:0]    deRsVal, deRtVal, deImm, dePc;
    functT                   deFunct;
    logic [RegAddrWidth-1:0] deDestReg;
    logic [TargetWidth-1:0]  deTarget;

    // Execute back to fetch and decode
    logic                 redirect;
    logic [DataWidth-1:0] redirectPc;

    fetchStage uFetch (
        .clk, .arstN, .redirect, .redirectPc,
        .imemAddr, .imemData, .fdInstr, .fdPc
    );

    decodeStage uDecode (
        .clk, .arstN, .fdInstr, .fdPc, .redirect,
        .wbEn, .wbReg, .wbData,
        .deRegWrite, .deMemRead, .deMemWrite, .deMemToReg,
        .deAluSrc, .deBranchEq, .deBranchNe, .deJump, .deAluOp,
        .deRsVal, .deRtVal, .deImm, .deFunct, .deDestReg, .deTarget, .dePc
    );

    executeStage uExecute (
        .deRegWrite, .deMemRead, .deMemWrite, .deMemToReg,
        .deAluSrc, .deBranchEq, .deBranchNe, .deJump, .deAluOp,
        .deRsVal, .deRtVal, .deImm, .deFunct, .deDestReg, .deTarget, .dePc,
        .dmemAddr, .dmemWData, .dmemWe, .dmemRData,
        .redirect, .redirectPc,
        .wbEn, .wbReg, .wbData
    );

endmodule

// ==== hw/mipsPkg.sv ====
package mipsPkg;

    localparam int DataWidth    = 32;   // Machine word
    localparam int RegAddrWidth = 5;    // 32 architectural registers
    localparam int ImmWidth     = 16;
    localparam int TargetWidth  = 26;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [5:0] opcodeT;

    localparam opcodeT OpRType = 6'b000000;  // ALU operation chosen by funct
    localparam opcodeT OpAddi  = 6'b001000;
    localparam opcodeT OpLw    = 6'b100011;
    localparam opcodeT OpSw    = 6'b101011;
    localparam opcodeT OpBeq   = 6'b000100;
    localparam opcodeT OpBne   = 6'b000101;
    localparam opcodeT OpJ     = 6'b000010;

    typedef logic [5:0] functT;

    localparam functT FnAdd = 6'b100000;
    localparam functT FnSub = 6'b100010;
    localparam functT FnAnd = 6'b100100;
    localparam functT FnOr  = 6'b100101;
    localparam functT FnSlt = 6'b101010;

    // Operation class from the main decoder
    typedef enum logic [1:0] {
        AluAdd   = 2'b00,   // Address calc and ADDI
        AluSub   = 2'b01,   // Branch compare
        AluFunct = 2'b10    // Look at funct
    } aluOpT;

    // Resolved ALU operation inside execute
    typedef enum logic [2:0] {
        AluCtlAdd,
        AluCtlSub,
        AluCtlAnd,
        AluCtlOr,
        AluCtlSlt
    } aluCtlT;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction word views
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        opcodeT                  opcode;
        logic [RegAddrWidth-1:0] rs;
        logic [RegAddrWidth-1:0] rt;
        logic [RegAddrWidth-1:0] rd;
        logic [4:0]              shamt;    // Unused by this subset
        functT                   funct;
    } rTypeT;

    typedef struct packed {
        opcodeT                  opcode;
        logic [RegAddrWidth-1:0] rs;
        logic [RegAddrWidth-1:0] rt;
        logic [ImmWidth-1:0]     imm;
    } iTypeT;

    typedef struct packed {
        opcodeT                 opcode;
        logic [TargetWidth-1:0] target;    // Word index within region
    } jTypeT;

    typedef union packed {
        rTypeT r;
        iTypeT i;
        jTypeT j;
    } instrT;

endpackage

// ==== sim.f ====
hw/mipsPkg.sv
hw/mainDecoder.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/mipsCore.sv
tb/clockGen.sv
tb/mipsCoreTb.sv

// ==== tb/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic arstN
);

    initial
    begin
        clk   = 1'b0;
        arstN = 1'b0;
        repeat (3) @(posedge clk);   // Three full cycles in reset
        @(negedge clk);
        arstN = 1'b1;                // Released on the falling edge
    end

    always #4 clk = ~clk;            // 8 ns period

endmodule

// ==== tb/mipsCoreTb.sv ====
`timescale 1ns/1ps

module mipsCoreTb;

    import mipsPkg::*;

    localparam int MemWords = 256;   // Both memories are word indexed by addr[9:2]
    localparam int NumTests = 6;

    logic                    clk;
    logic                    arstN;
    logic [DataWidth-1:0]    imemAddr;
    logic [DataWidth-1:0]    imemData;
    logic [DataWidth-1:0]    dmemAddr;
    logic [DataWidth-1:0]    dmemWData;
    logic [DataWidth-1:0]    dmemRData;
    logic                    dmemWe;
    logic                    wbEn;
    logic [RegAddrWidth-1:0] wbReg;
    logic [DataWidth-1:0]    wbData;

    instrT                imem   [MemWords];
    int                   secOf  [MemWords];   // Test each word belongs to
    logic [DataWidth-1:0] dmem   [MemWords];
    logic [DataWidth-1:0] refMem [MemWords];
    logic [DataWidth-1:0] refReg [32];

    // Expected events from the in-order model
    logic [DataWidth-1:0]    fetchQ[$];
    logic [RegAddrWidth-1:0] wantReg[$];
    logic [DataWidth-1:0]    wantData[$];
    logic [DataWidth-1:0]    storeAddr[$];
    logic [DataWidth-1:0]    storeData[$];

    int    cumFetch [NumTests];   // Running totals at the end of each test
    int    cumWrite [NumTests];
    int    cumStore [NumTests];
    string testName [NumTests] = '{"reset", "alu", "r0", "memory", "branch", "undef"};

    integer seed;
    int     progLen, branchCount, curSec;
    int     nFetch, nWrite, nStore;
    int     fetchSeen, writeSeen, storeSeen;
    int     errCount, checkCount, wdCycles;

    clockGen uClock (.clk, .arstN);

    mipsCore UUT (
        .clk, .arstN, .imemAddr, .imemData,
        .dmemAddr, .dmemWData, .dmemWe, .dmemRData,
        .wbEn, .wbReg, .wbData
    );

    ////////////////////////////////////////////////////////////////////////////
    // Memory models
    ////////////////////////////////////////////////////////////////////////////

    assign imemData  = imem[imemAddr[9:2]];
    assign dmemRData = dmem[dmemAddr[9:2]];

    always @(posedge clk)
    begin
        if (dmemWe)
            dmem[dmemAddr[9:2]] <= dmemWData;   // Lands at the closing edge
    end

    ////////////////////////////////////////////////////////////////////////////
    // Program builder
    ////////////////////////////////////////////////////////////////////////////

    function automatic int randRange(int lo, int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic instrT rType(functT fn, int rd, int rs, int rt);
        instrT w;
        w.r = '{OpRType, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
        return w;
    endfunction

    function automatic instrT iType(opcodeT op, int rt, int rs, int imm);
        instrT w;
        w.i = '{op, 5'(rs), 5'(rt), 16'(imm)};
        return w;
    endfunction

    function automatic instrT jType(int index);
        instrT w;
        w.j = '{OpJ, 26'(index)};   // Word index of the target
        return w;
    endfunction

    function automatic instrT undefWord(opcodeT op);
        instrT w;
        w          = $random(seed);   // Random fields behind a bad opcode
        w.r.opcode = op;
        return w;
    endfunction

    task automatic emit(instrT w);
        imem[progLen]  = w;
        secOf[progLen] = curSec;
        progLen++;
        if (w.r.opcode inside {OpBeq, OpBne, OpJ})
            branchCount++;
    endtask

    task automatic buildProgram();
        functT fnList [5];
        int    rd;
        int    prev;
        int    addr;
        fnList = '{FnAdd, FnSub, FnAnd, FnOr, FnSlt};
        curSec = 0;
        for (int r = 1; r < 8; r++)
            emit(iType(OpAddi, r, 0, randRange(-2000, 2000)));   // Defined values in r1..r7
        curSec = 1;
        prev   = 1;
        for (int k = 0; k < 20; k++)
        begin
            rd = randRange(1, 7);
            if (k % 4 == 3)
                emit(iType(OpAddi, rd, prev, randRange(-500, 500)));
            else
                emit(rType(fnList[k % 5], rd, prev, randRange(1, 7)));   // Reads last result
            prev = rd;
        end
        curSec = 2;
        emit(iType(OpAddi, 0, 1, 16'h1234));   // Dropped writes
        emit(rType(FnOr, 0, 2, 3));
        emit(rType(FnAdd, 4, 0, 0));           // r0 reads back as zero
        emit(iType(OpAddi, 5, 0, 16'h0042));
        curSec = 3;
        for (int k = 0; k < 6; k++)
        begin
            addr = randRange(0, MemWords - 1) * 4;
            emit(iType(OpSw, randRange(1, 7), 0, addr));
            emit(iType(OpLw, randRange(1, 7), 0, addr));   // Same word back
            emit(iType(OpLw, randRange(1, 7), 0, randRange(0, MemWords - 1) * 4));
        end
        curSec = 4;
        emit(iType(OpAddi, 6, 0, 1));
        emit(iType(OpAddi, 7, 0, 2));
        // Taken, not taken, taken, not taken; r6 and r7 stay fixed
        for (int k = 0; k < 4; k++)
        begin
            emit(iType(k < 2 ? OpBeq : OpBne, (k == 0 || k == 3) ? 6 : 7, 6, 2));
            for (int m = 0; m < 3; m++)
                emit(iType(OpAddi, randRange(1, 5), randRange(1, 7), randRange(-99, 99)));
        end
        emit(jType(progLen + 3));   // Skips the next two
        for (int m = 0; m < 3; m++)
            emit(iType(OpAddi, randRange(1, 5), randRange(1, 7), randRange(-99, 99)));
        curSec = 5;
        emit(undefWord(6'b111111));
        emit(undefWord(6'b001100));   // ANDI, outside the subset
        emit(iType(OpAddi, 1, 1, 7));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Architectural reference model, one instruction per step
    ////////////////////////////////////////////////////////////////////////////

    task automatic modelWrite(int rd, logic [DataWidth-1:0] v);
        if (rd != 0)
        begin
            refReg[rd] = v;
            wantReg.push_back(RegAddrWidth'(rd));
            wantData.push_back(v);
            nWrite++;
        end
    endtask

    task automatic runModel();
        logic [DataWidth-1:0] pc;
        logic [DataWidth-1:0] a, b, imm, res, target;
        instrT                w;
        int                   s;
        logic                 taken;
        pc = '0;
        while (pc < progLen * 4)
        begin
            w      = imem[pc[9:2]];
            s      = secOf[pc[9:2]];
            a      = refReg[w.i.rs];
            b      = refReg[w.i.rt];
            imm    = {{16{w.i.imm[15]}}, w.i.imm};
            taken  = 1'b0;
            target = pc + 4 + (imm << 2);
            fetchQ.push_back(pc);
            nFetch++;
            case (w.r.opcode)
                OpRType:
                begin
                    case (w.r.funct)
                        FnSub:   res = a - b;
                        FnAnd:   res = a & b;
                        FnOr:    res = a | b;
                        FnSlt:   res = ($signed(a) < $signed(b)) ? 1 : 0;
                        default: res = a + b;
                    endcase
                    modelWrite(w.r.rd, res);
                end
                OpAddi: modelWrite(w.i.rt, a + imm);
                OpLw:
                begin
                    res = a + imm;
                    modelWrite(w.i.rt, refMem[res[9:2]]);
                end
                OpSw:
                begin
                    res              = a + imm;
                    refMem[res[9:2]] = b;
                    storeAddr.push_back(res);
                    storeData.push_back(b);
                    nStore++;
                end
                OpBeq: taken = (a == b);
                OpBne: taken = (a != b);
                OpJ:
                begin
                    taken  = 1'b1;
                    res    = pc + 4;
                    target = {res[31:28], w.j.target, 2'b00};
                end
                default: ;   // No effect at all
            endcase
            if (taken)
            begin
                fetchQ.push_back(pc + 4);   // Two wrong-path fetches before the redirect
                fetchQ.push_back(pc + 8);
                nFetch += 2;
                pc = target;
            end
            else
                pc = pc + 4;
            cumFetch[s] = nFetch;
            cumWrite[s] = nWrite;
            cumStore[s] = nStore;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic checkValue(string name, logic [DataWidth-1:0] want,
                              logic [DataWidth-1:0] got);
        checkCount++;
        assert (got === want)
        else
        begin
            $display("ERR %s expected %h got %h at %0t", name, want, got, $time);
            errCount++;
        end
    endtask

    task automatic expectTrue(bit ok, string msg);
        checkCount++;
        assert (ok)
        else
        begin
            $display("%s at %0t", msg, $time);
            errCount++;
        end
    endtask

    // Outputs sampled before the flops update
    always @(posedge clk)
    begin
        if (arstN)
        begin
            if (fetchQ.size() > 0)
            begin
                checkValue("imemAddr", fetchQ.pop_front(), imemAddr);
                fetchSeen++;
            end
            if (wbEn)
            begin
                expectTrue(wantReg.size() > 0,
                           $sformatf("Unexpected register write to r%0d", wbReg));
                if (wantReg.size() > 0)
                begin
                    checkValue("wbReg", wantReg.pop_front(), wbReg);
                    checkValue("wbData", wantData.pop_front(), wbData);
                    writeSeen++;
                end
            end
            if (dmemWe)
            begin
                expectTrue(storeAddr.size() > 0, "Unexpected store to data memory");
                if (storeAddr.size() > 0)
                begin
                    checkValue("dmemAddr", storeAddr.pop_front(), dmemAddr);
                    checkValue("dmemWData", storeData.pop_front(), dmemWData);
                    storeSeen++;
                end
            end
        end
    end

    initial
    begin
        wait (wdCycles > 0);
        repeat (wdCycles) @(posedge clk);
        $display("Timeout, the program did not finish within %0d cycles", wdCycles);
        $display("TEST FAIL");
        $finish;
    end

    initial
    begin
        int errBase;
        seed = 32'hea5f;
        for (int i = 0; i < MemWords; i++)
        begin
            imem[i]   = '0;
            secOf[i]  = 0;
            dmem[i]   = (i * 32'h9e3779b1) ^ 32'h0f1e2d3c;   // Distinct per word
            refMem[i] = dmem[i];
        end
        for (int r = 0; r < 32; r++)
            refReg[r] = '0;
        buildProgram();
        runModel();
        wdCycles = 4 * (progLen + branchCount) + 50;

        @(posedge arstN);
        checkValue("imemAddr", '0, imemAddr);
        expectTrue(!wbEn && !dmemWe, "Strobe active at reset release");
        @(negedge clk);
        expectTrue(!wbEn && !dmemWe, "Strobe active before the first instruction reached execute");
        @(negedge clk);
        expectTrue(wbEn, "First register write missing two cycles after its fetch");

        errBase = 0;
        for (int s = 0; s < NumTests; s++)
        begin
            while (fetchSeen < cumFetch[s] || writeSeen < cumWrite[s] ||
                   storeSeen < cumStore[s])
                @(negedge clk);
            $display("Test %-7s done, %0d errors", testName[s], errCount - errBase);
            errBase = errCount;
        end
        repeat (4) @(negedge clk);   // Stray strobes after the last instruction
        $display("Tests %0d, checks %0d, errors %0d", NumTests, checkCount, errCount);
        if (errCount == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule
